// File: filelist.f
+incdir+hdl
hdl/regex_isa_pkg.sv
hdl/regex_mem_pkg.sv
hdl/regex_mem_if.sv
hdl/regex_char_walker.sv
hdl/regex_thread_engine.sv
hdl/regex_mem_arbiter.sv
hdl/regex_coprocessor.sv
dv/regex_tb_mem.sv
dv/regex_tb.sv

// File: Bender.yml
package:
  name: regex_coprocessor

sources:
  # design
  - include_dirs:
      - hdl
    files:
      - hdl/regex_isa_pkg.sv
      - hdl/regex_mem_pkg.sv
      - hdl/regex_mem_if.sv
      - hdl/regex_char_walker.sv
      - hdl/regex_thread_engine.sv
      - hdl/regex_mem_arbiter.sv
      - hdl/regex_coprocessor.sv
  # testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/regex_tb_mem.sv
      - dv/regex_tb.sv

// File: dv/regex_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "regex_settings.svh"

module regex_tb;
    import regex_isa_pkg::*;
    import regex_mem_pkg::*;

    localparam int        SEED           = 40898;
    localparam int        PROG_LEN       = 8;
    localparam int        NUM_DIRECTED   = 12;
    localparam int        NUM_RANDOM     = 48;
    localparam int        NUM_JOBS       = NUM_DIRECTED + NUM_RANDOM;
    localparam int        TIMEOUT_CYCLES = NUM_JOBS * 2000;
    localparam mem_addr_t STR_BASE       = 512;

    logic      clk;
    logic      reset;
    logic      start;
    mem_addr_t start_ptr;
    logic      start_ack;
    logic      finish;
    logic      accept;
    logic      mem_valid;
    mem_addr_t mem_addr;
    logic      mem_ready;
    mem_word_u mem_data;

    // programs as the reference walks them, one per row
    instr_t    progs [4][PROG_LEN];
    logic      exp_q [$];
    integer    seed;
    int        job_idx;
    int        ack_count;
    int        finish_count;
    int        cycle_count;
    logic      stalled;
    mem_addr_t stalled_addr;

    regex_coprocessor u_regex_coprocessor
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .start_ptr (start_ptr),
        .start_ack (start_ack),
        .finish    (finish),
        .accept    (accept),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_data  (mem_data)
    );

    regex_tb_mem #(.SEED(SEED)) u_regex_tb_mem
    (
        .clk       (clk),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_data  (mem_data)
    );

    always #2 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_accept(input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("ERR %0t: job %0d accept is %b, reference expects %b",
                                   $time, finish_count, got, exp));
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp)
            report_error($sformatf("ERR %0t: mem_addr moved from %0d to %0d during a stall",
                                   $time, exp, got));
    endtask

    function automatic instr_t encode_instr(input opcode_e op, input pc_t operand);
        instr_t w;
        w.opcode  = op;
        w.unused  = '0;
        w.operand = operand;
        return w;
    endfunction

    // live pc set per character, epsilon closure through JMP and SPLIT
    function automatic logic regex_ref(input int prog, input string s);
        pc_t    cur_set [$];
        pc_t    next_set [$];
        pc_t    work [$];
        bit     seen [PROG_LEN];
        instr_t ins;
        pc_t    pc;
        char_t  c;
        cur_set.push_back(pc_t'(0));
        for (int pos = 0; pos <= s.len(); pos++)
        begin
            // the terminator is the last position a thread can accept at
            c = (pos < s.len()) ? char_t'(s[pos]) : char_t'(`REGEX_TERMINATOR);
            work = cur_set;
            next_set.delete();
            for (int i = 0; i < PROG_LEN; i++)
                seen[i] = 1'b0;
            while (work.size() != 0)
            begin
                pc = work.pop_back();
                if (!seen[pc])
                begin
                    seen[pc] = 1'b1;
                    ins      = progs[prog][pc];
                    case (ins.opcode)
                        OP_ACCEPT:
                            return 1'b1;
                        OP_JMP:
                            work.push_back(ins.operand);
                        OP_SPLIT:
                        begin
                            work.push_back(pc_t'(pc + 1));
                            work.push_back(ins.operand);
                        end
                        default:
                            if (ins.operand == c)
                                next_set.push_back(pc_t'(pc + 1));
                    endcase
                end
            end
            // nothing survived, or no character left
            if (pos == s.len() || next_set.size() == 0)
                return 1'b0;
            cur_set = next_set;
        end
        return 1'b0;
    endfunction

    task automatic build_programs();
        for (int p = 0; p < 4; p++)
            for (int i = 0; i < PROG_LEN; i++)
                progs[p][i] = encode_instr(OP_ACCEPT, '0);
        // literal abc
        progs[0][0] = encode_instr(OP_MATCH, pc_t'("a"));
        progs[0][1] = encode_instr(OP_MATCH, pc_t'("b"));
        progs[0][2] = encode_instr(OP_MATCH, pc_t'("c"));
        // ab|cd, both arms meet at the ACCEPT in word 6
        progs[1][0] = encode_instr(OP_SPLIT, pc_t'(4));
        progs[1][1] = encode_instr(OP_MATCH, pc_t'("a"));
        progs[1][2] = encode_instr(OP_MATCH, pc_t'("b"));
        progs[1][3] = encode_instr(OP_JMP, pc_t'(6));
        progs[1][4] = encode_instr(OP_MATCH, pc_t'("c"));
        progs[1][5] = encode_instr(OP_MATCH, pc_t'("d"));
        // a*b with the loop back to the SPLIT
        progs[2][0] = encode_instr(OP_SPLIT, pc_t'(3));
        progs[2][1] = encode_instr(OP_MATCH, pc_t'("a"));
        progs[2][2] = encode_instr(OP_JMP, pc_t'(0));
        progs[2][3] = encode_instr(OP_MATCH, pc_t'("b"));
        // program 3 is ACCEPT alone
    endtask

    task automatic load_program(input int prog);
        mem_word_u w;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            w.instr = progs[prog][i];
            u_regex_tb_mem.words[i] = w;
        end
    endtask

    // even index in the low byte, terminator written after the last character
    task automatic load_string(input mem_addr_t base, input string s);
        mem_word_u w;
        for (int i = 0; i <= s.len(); i += 2)
        begin
            w.chars.lo = (i < s.len()) ? char_t'(s[i]) : char_t'(`REGEX_TERMINATOR);
            w.chars.hi = (i + 1 < s.len()) ? char_t'(s[i + 1]) : char_t'(`REGEX_TERMINATOR);
            u_regex_tb_mem.words[base + mem_addr_t'(i / 2)] = w;
        end
    endtask

    // want is -1 for random jobs, else the value the directed case spells out
    task automatic run_job(input int prog, input string s, input int want);
        mem_addr_t base;
        logic      ref_accept;
        base       = STR_BASE + mem_addr_t'(16 * (job_idx % 96));
        ref_accept = regex_ref(prog, s);
        if (want >= 0 && ref_accept !== want[0])
            report_error($sformatf("reference model disagrees on program %0d, string '%s'",
                                   prog, s));
        load_program(prog);
        load_string(base, s);
        exp_q.push_back(ref_accept);
        @(posedge clk);
        #1;
        start     = 1'b1;
        start_ptr = base;
        // start held until the walker takes the first word
        do
            @(negedge clk);
        while (!start_ack);
        @(posedge clk);
        #1;
        start = 1'b0;
        do
            @(negedge clk);
        while (!finish);
        job_idx++;
    endtask

    // one finish per start_ack, accept against the reference
    always @(negedge clk)
    begin
        if (!reset && start_ack)
        begin
            if (ack_count != finish_count)
                report_error("start_ack came while the previous job had not finished");
            ack_count++;
        end
        if (!reset && finish)
        begin
            if (finish_count + 1 != ack_count)
                report_error("finish pulsed without a matching start_ack");
            if (exp_q.size() == 0)
                report_error("finish pulsed with no job outstanding");
            check_accept(accept, exp_q.pop_front());
            finish_count++;
        end
    end

    // a stalled request keeps valid and address until the memory takes it
    always @(negedge clk)
    begin
        if (reset)
            stalled = 1'b0;
        else
        begin
            if (stalled)
            begin
                if (!mem_valid)
                    report_error("mem_valid dropped before the memory accepted the request");
                check_addr(mem_addr, stalled_addr);
            end
            stalled      = mem_valid && !mem_ready;
            stalled_addr = mem_addr;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_error($sformatf("run timed out after %0d cycles", cycle_count));
    end

    initial
    begin
        int    prog;
        int    len;
        string s;
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        start_ptr    = '0;
        seed         = SEED;
        job_idx      = 0;
        ack_count    = 0;
        finish_count = 0;
        cycle_count  = 0;
        build_programs();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);

        // literal abc
        run_job(0, "abcd", 1);
        run_job(0, "abd", 0);
        // alternation
        run_job(1, "ab", 1);
        run_job(1, "cd", 1);
        run_job(1, "ac", 0);
        // loop
        run_job(2, "aaab", 1);
        run_job(2, "b", 1);
        run_job(2, "aaa", 0);
        // empty string, only a leading ACCEPT takes it
        run_job(0, "", 0);
        run_job(1, "", 0);
        run_job(2, "", 0);
        run_job(3, "", 1);

        // back to back random jobs over a, b and c
        for (int j = 0; j < NUM_RANDOM; j++)
        begin
            prog = ($random(seed) & 32'h7fff_ffff) % 4;
            len  = ($random(seed) & 32'h7fff_ffff) % 11;
            s    = "";
            for (int k = 0; k < len; k++)
                s = $sformatf("%s%c", s, 8'h61 + (($random(seed) & 32'h7fff_ffff) % 3));
            run_job(prog, s, -1);
        end

        @(posedge clk);
        #1;
        if (finish_count == NUM_JOBS && exp_q.size() == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d jobs finished", finish_count, NUM_JOBS);
            $display("Regression failed");
            $fatal(1, "job count mismatch at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: dv/regex_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

// word memory behind the coprocessor port
// random ready stalls, read word one cycle after the accepted request
module regex_tb_mem
#(
    parameter int SEED = 1
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_valid,
    input  regex_mem_pkg::mem_addr_t mem_addr,
    output logic                     mem_ready,
    output regex_mem_pkg::mem_word_u mem_data
);
    import regex_mem_pkg::*;

    localparam int WORDS = 2 ** $bits(mem_addr_t);

    // programs from word 0, strings from word 512, loaded by the testbench
    mem_word_u words [WORDS];
    integer    seed;
    logic      taken;
    mem_addr_t taken_addr;

    initial
    begin
        seed      = SEED;
        mem_ready = 1'b0;
        mem_data  = '0;
        // background pattern built from every address bit
        for (int i = 0; i < WORDS; i++)
            words[i] = mem_word_u'(16'(i) ^ (16'(i) << 5) ^ 16'h5a3c);
        forever
        begin
            @(posedge clk);
            // handshake as seen at the edge
            taken      = mem_valid && mem_ready;
            taken_addr = mem_addr;
            #1;
            // word of the accepted request for the following cycle
            if (taken)
                mem_data = words[taken_addr];
            // roughly one stall in four cycles
            mem_ready = !reset && (($random(seed) & 3) != 0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/regex_coprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module regex_coprocessor
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  regex_mem_pkg::mem_addr_t start_ptr,
    output logic                     start_ack,
    output logic                     finish,
    output logic                     accept,
    output logic                     mem_valid,
    output regex_mem_pkg::mem_addr_t mem_addr,
    input  logic                     mem_ready,
    input  regex_mem_pkg::mem_word_u mem_data
);
    import regex_isa_pkg::*;

    // walker to engine control
    logic  go;
    logic  advance;
    logic  flush;
    char_t cur_char;

    // engine status back to the walker
    logic  running;
    logic  accepts;

    // one memory port per requester
    regex_mem_if walker_mem ();
    regex_mem_if engine_mem ();

    regex_char_walker u_regex_char_walker
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .start_ptr (start_ptr),
        .running   (running),
        .accepts   (accepts),
        .start_ack (start_ack),
        .finish    (finish),
        .accept    (accept),
        .go        (go),
        .advance   (advance),
        .flush     (flush),
        .cur_char  (cur_char),
        .mem       (walker_mem.requester)
    );

    regex_thread_engine u_regex_thread_engine
    (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .go       (go),
        .advance  (advance),
        .cur_char (cur_char),
        .running  (running),
        .accepts  (accepts),
        .mem      (engine_mem.requester)
    );

    // walker takes port 0 and wins ties
    regex_mem_arbiter u_regex_mem_arbiter
    (
        .walker    (walker_mem.arbiter),
        .engine    (engine_mem.arbiter),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_data  (mem_data)
    );

endmodule

`default_nettype wire

// File: hdl/regex_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module regex_mem_arbiter
(
    regex_mem_if.arbiter              walker,
    regex_mem_if.arbiter              engine,
    output logic                      mem_valid,
    output regex_mem_pkg::mem_addr_t  mem_addr,
    input  logic                      mem_ready,
    input  regex_mem_pkg::mem_word_u  mem_data
);
    logic grant_walker;
    logic grant_engine;

    // walker has fixed priority over the engine
    assign grant_walker = walker.valid;
    assign grant_engine = engine.valid && !walker.valid;

    always_comb
    begin
        mem_valid = walker.valid || engine.valid;
        if (grant_walker)
            mem_addr = walker.addr;
        else
            mem_addr = engine.addr;
    end

    // memory ready only reaches the granted side
    assign walker.ready = mem_ready && grant_walker;
    assign engine.ready = mem_ready && grant_engine;

    // same word for both
    // only the side that saw ready takes it
    assign walker.data = mem_data;
    assign engine.data = mem_data;

    // at most one request accepted per cycle
    assert final (!(walker.ready && engine.ready));

endmodule

`default_nettype wire

// File: hdl/regex_thread_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "regex_settings.svh"

module regex_thread_engine
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 go,
    input  logic                 advance,
    input  regex_isa_pkg::char_t cur_char,
    output logic                 running,
    output logic                 accepts,
    regex_mem_if.requester       mem
);
    import regex_isa_pkg::*;
    import regex_mem_pkg::*;

    localparam int  DEPTH    = `REGEX_LIST_DEPTH;
    localparam int  IDX_W    = $clog2(DEPTH);
    localparam int  CNT_W    = $clog2(DEPTH + 1);
    localparam pc_t START_PC = '0;

    // two stacks of pcs, one for the current and one for the next character
    pc_t              list_mem [2][DEPTH];
    logic [CNT_W-1:0] list_cnt [2];
    logic             cur_sel;
    logic             nxt_sel;
    logic             cur_busy;
    logic [CNT_W-1:0] top_cnt;
    pc_t              top_pc;
    logic             fetch_req;
    logic             pop;
    logic             inflight;
    pc_t              exec_pc;
    pc_t              exec_pc_inc;
    logic             split_pending;
    pc_t              split_pc;
    instr_t           instr;
    logic             push_en;
    logic             push_sel;
    pc_t              push_pc;
    logic [IDX_W-1:0] push_idx;

    assign nxt_sel = ~cur_sel;
    assign top_cnt = list_cnt[cur_sel] - 1'b1;
    assign top_pc  = list_mem[cur_sel][top_cnt[IDX_W-1:0]];

    // one instruction at a time
    // the split follow-up also blocks the next pop
    assign cur_busy  = inflight || split_pending;
    assign fetch_req = go && !cur_busy && (list_cnt[cur_sel] != '0);
    assign pop       = fetch_req && mem.ready;

    // fetch straight from the top of the current list
    assign mem.valid = fetch_req;
    assign mem.addr  = mem_addr_t'(top_pc);

    // returned word decoded as an instruction
    assign instr       = mem.data.instr;
    assign exec_pc_inc = exec_pc + 1'b1;

    assign accepts = inflight && (instr.opcode == OP_ACCEPT);
    assign running = (list_cnt[cur_sel] != '0) || cur_busy;

    always_comb
    begin
        push_en  = 1'b0;
        push_sel = cur_sel;
        push_pc  = exec_pc_inc;
        if (split_pending)
        begin
            // second half of SPLIT
            push_en = 1'b1;
            push_pc = split_pc;
        end
        else if (inflight)
        begin
            case (instr.opcode)
                OP_MATCH:
                begin
                    // survivor waits for the next character
                    if (instr.operand == cur_char)
                    begin
                        push_en  = 1'b1;
                        push_sel = nxt_sel;
                    end
                end
                OP_JMP:
                begin
                    push_en = 1'b1;
                    push_pc = instr.operand;
                end
                OP_SPLIT:
                    push_en = 1'b1;
                default:
                    push_en = 1'b0;
            endcase
        end
    end

    assign push_idx = list_cnt[push_sel][IDX_W-1:0];

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            // start pc alone in the current list
            cur_sel       <= 1'b0;
            list_cnt[0]   <= CNT_W'(1);
            list_cnt[1]   <= '0;
            inflight      <= 1'b0;
            split_pending <= 1'b0;
        end
        else
        begin
            if (advance)
                cur_sel <= nxt_sel;
            if (pop)
                list_cnt[cur_sel] <= list_cnt[cur_sel] - 1'b1;
            if (push_en)
                list_cnt[push_sel] <= list_cnt[push_sel] + 1'b1;
            inflight      <= pop;
            split_pending <= inflight && (instr.opcode == OP_SPLIT);
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            exec_pc <= top_pc;
        if (inflight)
            split_pc <= instr.operand;
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
            list_mem[0][0] <= START_PC;
        else if (push_en)
            list_mem[push_sel][push_idx] <= push_pc;
    end

    // thread programs must fit into the list depth
    assert property (@(posedge clk) disable iff (reset || flush)
        push_en |-> list_cnt[push_sel] < CNT_W'(DEPTH));

    // walker only moves on once every thread of this character is done
    assert property (@(posedge clk) disable iff (reset || flush)
        advance |-> !running);

endmodule

`default_nettype wire

// File: hdl/regex_char_walker.sv
`timescale 1ns/1ps
`default_nettype none
`include "regex_settings.svh"

module regex_char_walker
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  regex_mem_pkg::mem_addr_t start_ptr,
    input  logic                     running,
    input  logic                     accepts,
    output logic                     start_ack,
    output logic                     finish,
    output logic                     accept,
    output logic                     go,
    output logic                     advance,
    output logic                     flush,
    output regex_isa_pkg::char_t     cur_char,
    regex_mem_if.requester           mem
);
    import regex_isa_pkg::*;
    import regex_mem_pkg::*;

    // character index has one extra bit for the byte inside a word
    localparam int IDX_W = `REGEX_MEM_ADDR_WIDTH + 1;

    typedef enum logic [2:0]
    {
        idle,
        fetch_first,
        exec,
        fetch_next,
        done_accept,
        done_reject
    } state_e;

    state_e           state;
    state_e           state_next;
    logic [IDX_W-1:0] char_idx;
    logic [IDX_W-1:0] idx_next;
    logic [IDX_W-1:0] step_idx;
    mem_addr_t        base_ptr;
    mem_addr_t        base_next;
    mem_addr_t        step_addr;
    char_t            char_next;
    char_t            word_char;

    // index and word of the following character
    assign step_idx  = char_idx + 1'b1;
    assign step_addr = base_ptr + step_idx[IDX_W-1:1];

    // low index bit picks the byte of the returned word
    assign word_char = char_idx[0] ? mem.data.chars.hi : mem.data.chars.lo;

    always_comb
    begin
        state_next = state;
        idx_next   = char_idx;
        base_next  = base_ptr;
        char_next  = cur_char;
        start_ack  = 1'b0;
        finish     = 1'b0;
        accept     = 1'b0;
        go         = 1'b0;
        advance    = 1'b0;
        flush      = 1'b0;
        mem.valid  = 1'b0;
        mem.addr   = step_addr;
        case (state)
            idle:
            begin
                // first word request goes out with the start request
                mem.valid = start;
                mem.addr  = start_ptr;
                if (start && mem.ready)
                begin
                    start_ack  = 1'b1;
                    base_next  = start_ptr;
                    idx_next   = '0;
                    state_next = fetch_first;
                end
            end
            fetch_first:
            begin
                char_next  = word_char;
                state_next = exec;
            end
            exec:
            begin
                go = 1'b1;
                if (accepts)
                    state_next = done_accept;
                else if (!running)
                begin
                    // all threads of this character are done
                    if (cur_char == char_t'(`REGEX_TERMINATOR))
                        state_next = done_reject;
                    else
                    begin
                        mem.valid = 1'b1;
                        if (mem.ready)
                        begin
                            advance    = 1'b1;
                            idx_next   = step_idx;
                            state_next = fetch_next;
                        end
                    end
                end
            end
            fetch_next:
            begin
                char_next = word_char;
                // no thread survived the last character
                if (running)
                    state_next = exec;
                else
                    state_next = done_reject;
            end
            done_accept, done_reject:
            begin
                finish     = 1'b1;
                accept     = (state == done_accept);
                flush      = 1'b1;
                state_next = idle;
            end
            default:
                state_next = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= idle;
            char_idx <= '0;
        end
        else
        begin
            state    <= state_next;
            char_idx <= idx_next;
        end
    end

    always_ff @(posedge clk)
    begin
        base_ptr <= base_next;
        cur_char <= char_next;
    end

    // the engine sees one character for the whole exec phase
    assert property (@(posedge clk) disable iff (reset) go ##1 go |-> $stable(cur_char));

endmodule

`default_nettype wire

// File: hdl/regex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// one memory requester towards the arbiter
interface regex_mem_if;

    import regex_mem_pkg::*;

    // request side, held until ready
    logic      valid;
    mem_addr_t addr;

    // accept strobe from the arbiter
    logic      ready;

    // word of an accepted request, one cycle later
    // broadcast to every requester
    mem_word_u data;

    modport requester
    (
        output valid,
        output addr,
        input  ready,
        input  data
    );

    modport arbiter
    (
        input  valid,
        input  addr,
        output ready,
        output data
    );

endinterface

`default_nettype wire

// File: hdl/regex_mem_pkg.sv
`default_nettype none
`include "regex_settings.svh"

package regex_mem_pkg;

    import regex_isa_pkg::*;

    // word address into the shared program and string memory
    typedef logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // string view of a word
    // even character index sits in the low byte
    typedef struct packed
    {
        char_t hi;
        char_t lo;
    } char_pair_t;

    // same word seen by the walker as characters and by the engine as an instruction
    typedef union packed
    {
        char_pair_t chars;
        instr_t     instr;
    } mem_word_u;

endpackage

`default_nettype wire

// File: hdl/regex_isa_pkg.sv
`default_nettype none
`include "regex_settings.svh"

package regex_isa_pkg;

    // program counter and character
    typedef logic [`REGEX_PC_WIDTH-1:0]   pc_t;
    typedef logic [`REGEX_CHAR_WIDTH-1:0] char_t;

    // two bit opcode in the top of every instruction word
    typedef enum logic [1:0]
    {
        OP_MATCH  = 2'd0,
        OP_JMP    = 2'd1,
        OP_SPLIT  = 2'd2,
        OP_ACCEPT = 2'd3
    } opcode_e;

    // operand is a character for MATCH and a target pc for JMP and SPLIT
    typedef struct packed
    {
        opcode_e                                   opcode;
        logic [`REGEX_MEM_WIDTH-`REGEX_PC_WIDTH-3:0] unused;
        logic [`REGEX_PC_WIDTH-1:0]                operand;
    } instr_t;

endpackage

`default_nettype wire

// File: hdl/regex_settings.svh
`ifndef REGEX_SETTINGS_SVH
`define REGEX_SETTINGS_SVH

// program counter width, programs live at word addresses 0 to 255
`define REGEX_PC_WIDTH 8

// one string character
`define REGEX_CHAR_WIDTH 8

// memory is 16 bits wide and holds two characters or one instruction
`define REGEX_MEM_WIDTH 16
`define REGEX_MEM_ADDR_WIDTH 11

// entries in each of the two thread lists
`define REGEX_LIST_DEPTH 16

// strings are zero terminated
`define REGEX_TERMINATOR 0

`endif
